/* hdl/vec_decode_pkg.sv */
package vec_decode_pkg;

    localparam int inst_w = 32;

    typedef enum logic [6:0] {
        V_ARITH = 7'b1010111,
        V_LOAD  = 7'b0000111,
        V_STORE = 7'b0100111
    } v_opcode_e;

    // funct3 picks the operand category or the config group
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVX = 3'b100,
        OPIVI = 3'b011,
        OPMVV = 3'b010,
        OPMVX = 3'b110,
        CONF  = 3'b111
    } v_func3_e;

    typedef enum logic [5:0] {
        VADD   = 6'b000000,
        VSUB   = 6'b000010,
        VRSUB  = 6'b000011,
        VMINU  = 6'b000100,
        VMIN   = 6'b000101,
        VMAXU  = 6'b000110,
        VMAX   = 6'b000111,
        VAND   = 6'b001001,
        VOR    = 6'b001010,
        VXOR   = 6'b001011,
        VMSEQ  = 6'b011000,
        VMSNE  = 6'b011001,
        VMSLTU = 6'b011010,
        VMSLT  = 6'b011011,
        VMSLEU = 6'b011100,
        VMSLE  = 6'b011101,
        VMSGTU = 6'b011110,
        VMSGT  = 6'b011111,
        VSLL   = 6'b100101,
        VSRL   = 6'b101000,
        VSRA   = 6'b101001
    } v_func6_vix_e;

    typedef enum logic [5:0] {
        VMULHU  = 6'b100100,
        VMUL    = 6'b100101,
        VMULHSU = 6'b100110,
        VMULH   = 6'b100111
    } v_func6_vx_e;

    typedef enum logic [1:0] {
        MOP_UNIT      = 2'b00,
        MOP_IDX_UNORD = 2'b01,
        MOP_STRIDED   = 2'b10,
        MOP_IDX_ORD   = 2'b11
    } mop_e;

    typedef enum logic [2:0] {
        EXE_ADDSUB = 3'd0,
        EXE_SHIFT  = 3'd1,
        EXE_LOGIC  = 3'd2,
        EXE_MUL    = 3'd3
    } exe_unit_e;

    typedef enum logic [1:0] {
        MUX1_VEC    = 2'd0,
        MUX1_SCALAR = 2'd1,
        MUX1_IMM    = 2'd2
    } mux1_sel_e;

    typedef struct packed {
        logic [5:0] func6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1_rs1;     // vs1, rs1 or simm5
        v_func3_e   func3;
        logic [4:0] vd;
        v_opcode_e  opcode;
    } arith_view_t;

    typedef struct packed {
        logic       sel_hi;      // low for vsetvli
        logic       sel_ivli;    // high for vsetivli
        logic [9:0] zimm;
        logic [4:0] rs1;
        v_func3_e   func3;
        logic [4:0] rd;
        v_opcode_e  opcode;
    } cfg_view_t;

    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        mop_e       mop;
        logic       vm;
        logic [4:0] rs2;         // stride reg or index vreg
        logic [4:0] rs1;         // base address
        logic [2:0] width;
        logic [4:0] vd;
        v_opcode_e  opcode;
    } mem_view_t;

    typedef union packed {
        arith_view_t arith;
        cfg_view_t   cfg;
        mem_view_t   mem;
    } vec_inst_u;

    typedef struct packed {
        logic csr_wr_en;
        logic vl_sel;            // rs1 data or uimm
        logic vtype_sel;         // rs2 data or zimm
        logic rs1rd_de;          // vlmax or comparator
    } cfg_ctrl_t;

    typedef struct packed {
        mux1_sel_e data_mux1_sel;
        logic      data_mux2_sel;    // scalar2 vs vector data2
        logic      vec_reg_wr_en;
        logic      sew_eew_sel;
        logic      vlmax_evlmax_sel;
        logic      emul_vlmul_sel;
    } opnd_ctrl_t;

    typedef struct packed {
        logic ld_inst;
        logic st_inst;
        logic stride_sel;        // unit stride
        logic index_str;
        logic index_unordered;
        logic offset_vec_en;     // data2 used as offset vector
    } mem_ctrl_t;

    typedef struct packed {
        logic      exe_en;
        exe_unit_e exe_unit;
        logic      sub_ctrl;
        logic      add_inst;
        logic      sub_inst;
        logic      rsub_inst;
        logic      sll_inst;
        logic      srl_inst;
        logic      sra_inst;
        logic      mul_inst;
        logic      mul_low;
        logic      mul_high;
        logic      signed_mode;
    } exe_ctrl_t;

    typedef struct packed {
        cfg_ctrl_t  cfg;
        opnd_ctrl_t opnd;
        mem_ctrl_t  mem;
        exe_ctrl_t  exe;
    } vec_ctrl_t;

endpackage

/* hdl/vec_arith_decode.sv */
`timescale 1ns/10ps

module vec_arith_decode import vec_decode_pkg::*; (
    input  vec_inst_u inst,
    output vec_ctrl_t ctrl
);

    v_func6_vix_e func6_vix;
    v_func6_vx_e  func6_vx;
    mux1_sel_e    mux1;
    logic         is_vv;
    logic         is_vi;

    // one funct6 field, read as integer or multiply op
    assign func6_vix = v_func6_vix_e'(inst.arith.func6);
    assign func6_vx  = v_func6_vx_e'(inst.arith.func6);
    assign is_vv     = (inst.arith.func3 == OPIVV);
    assign is_vi     = (inst.arith.func3 == OPIVI);

    always_comb begin
        case (inst.arith.func3)
            OPIVX, OPMVX: mux1 = MUX1_SCALAR;   // rs1 data
            OPIVI:        mux1 = MUX1_IMM;      // simm5
            default:      mux1 = MUX1_VEC;
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (inst.arith.opcode == V_ARITH) begin
            case (inst.arith.func3)
                OPIVV, OPIVX, OPIVI: begin
                    ctrl.opnd.vec_reg_wr_en = 1'b1;
                    ctrl.opnd.data_mux1_sel = mux1;
                    case (func6_vix)
                        VADD: begin
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.add_inst = 1'b1;
                        end
                        VSUB: if (!is_vi) begin     // no immediate form
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.sub_inst = 1'b1;
                            ctrl.exe.sub_ctrl = 1'b1;
                        end
                        VRSUB: if (!is_vv) begin    // scalar or imm only
                            ctrl.exe.exe_en    = 1'b1;
                            ctrl.exe.rsub_inst = 1'b1;
                            ctrl.exe.sub_ctrl  = 1'b1;
                        end
                        VSLL, VSRL, VSRA: begin
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.exe_unit = EXE_SHIFT;
                            if (is_vv) begin
                                ctrl.exe.sll_inst = (func6_vix == VSLL);
                                ctrl.exe.srl_inst = (func6_vix == VSRL);
                                ctrl.exe.sra_inst = (func6_vix == VSRA);
                            end
                        end
                        VAND, VOR, VXOR, VMSEQ, VMSNE, VMSLEU, VMSLE: begin
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.exe_unit = EXE_LOGIC;
                        end
                        VMSLTU, VMSLT, VMINU, VMIN, VMAXU, VMAX: if (!is_vi) begin
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.exe_unit = EXE_LOGIC;
                        end
                        VMSGTU, VMSGT: if (!is_vv) begin
                            ctrl.exe.exe_en   = 1'b1;
                            ctrl.exe.exe_unit = EXE_LOGIC;
                        end
                        default: ;
                    endcase
                end
                OPMVV, OPMVX: begin
                    ctrl.opnd.vec_reg_wr_en = 1'b1;
                    ctrl.opnd.data_mux1_sel = mux1;
                    case (func6_vx)
                        VMUL, VMULH, VMULHU, VMULHSU: begin
                            ctrl.exe.exe_en      = 1'b1;
                            ctrl.exe.exe_unit    = EXE_MUL;
                            ctrl.exe.mul_inst    = 1'b1;
                            ctrl.exe.mul_low     = (func6_vx == VMUL);
                            ctrl.exe.mul_high    = (func6_vx != VMUL);
                            ctrl.exe.signed_mode = (func6_vx != VMULHU);
                        end
                        default: ;
                    endcase
                end
                default: ;                          // CONF handled elsewhere
            endcase
        end
    end

endmodule

/* hdl/vec_cfg_decode.sv */
`timescale 1ns/10ps

module vec_cfg_decode import vec_decode_pkg::*; (
    input  vec_inst_u inst,
    output vec_ctrl_t ctrl
);

    logic is_cfg;
    logic is_ivli;
    logic avl_vlmax;

    assign is_cfg  = (inst.cfg.opcode == V_ARITH) && (inst.cfg.func3 == CONF);
    assign is_ivli = inst.cfg.sel_hi && inst.cfg.sel_ivli;

    // rs1=x0 with rd!=x0 requests vl = vlmax
    assign avl_vlmax = (inst.cfg.rs1 == 5'd0) && (inst.cfg.rd != 5'd0);

    always_comb begin
        ctrl = '0;
        if (is_cfg) begin
            ctrl.cfg.csr_wr_en = 1'b1;
            if (!inst.cfg.sel_hi) begin         // vsetvli
                ctrl.cfg.vtype_sel = 1'b1;      // zimm
            end else if (inst.cfg.sel_ivli) begin
                ctrl.cfg.vl_sel    = 1'b1;      // uimm
                ctrl.cfg.vtype_sel = 1'b1;
            end
            // vsetivli carries avl as an immediate, never vlmax
            ctrl.cfg.rs1rd_de = is_ivli || !avl_vlmax;
        end
    end

endmodule

/* hdl/vec_mem_decode.sv */
`timescale 1ns/10ps

module vec_mem_decode import vec_decode_pkg::*; (
    input  vec_inst_u inst,
    output vec_ctrl_t ctrl
);

    logic is_ld;
    logic is_st;

    assign is_ld = (inst.mem.opcode == V_LOAD);
    assign is_st = (inst.mem.opcode == V_STORE);

    always_comb begin
        ctrl = '0;
        if (is_ld || is_st) begin
            ctrl.mem.ld_inst        = is_ld;
            ctrl.mem.st_inst        = is_st;
            ctrl.opnd.vec_reg_wr_en = 1'b1;
            ctrl.opnd.data_mux1_sel = MUX1_SCALAR;     // base address
            case (inst.mem.mop)
                MOP_UNIT, MOP_STRIDED: begin
                    ctrl.mem.stride_sel        = (inst.mem.mop == MOP_UNIT);
                    ctrl.opnd.data_mux2_sel    = 1'b1;  // scalar stride
                    ctrl.opnd.sew_eew_sel      = 1'b1;  // eew
                    ctrl.opnd.vlmax_evlmax_sel = 1'b1;  // evlmax
                    ctrl.opnd.emul_vlmul_sel   = 1'b1;  // emul
                end
                MOP_IDX_UNORD, MOP_IDX_ORD: begin
                    // index vector read as offsets, element width from sew
                    ctrl.mem.index_str         = 1'b1;
                    ctrl.mem.offset_vec_en     = 1'b1;
                    ctrl.mem.index_unordered   = (inst.mem.mop == MOP_IDX_UNORD);
                    ctrl.opnd.vlmax_evlmax_sel = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

/* hdl/vec_issue_fsm.sv */
`timescale 1ns/10ps

module vec_issue_fsm import vec_decode_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              vec_req,
    input  logic [inst_w-1:0] vec_inst,
    output logic              vec_ack,
    output vec_inst_u         inst_q,
    input  vec_ctrl_t         arith_ctrl,
    input  vec_ctrl_t         cfg_ctrl,
    input  vec_ctrl_t         mem_ctrl,
    output vec_ctrl_t         ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        ACK
    } state_e;

    state_e    state;
    vec_ctrl_t merged;

    // decoders zero every field they do not own
    assign merged = vec_ctrl_t'(arith_ctrl | cfg_ctrl | mem_ctrl);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            vec_ack <= 1'b0;
            ctrl    <= '0;
        end else begin
            case (state)
                IDLE: if (vec_req) begin
                    state <= DECODE;
                end
                DECODE: begin
                    ctrl    <= merged;      // held until next capture
                    vec_ack <= 1'b1;
                    state   <= ACK;
                end
                ACK: if (!vec_req) begin    // core released req
                    vec_ack <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // instruction register, only loaded on accept
    always_ff @(posedge clk) begin
        if (state == IDLE && vec_req) begin
            inst_q <= vec_inst_u'(vec_inst);
        end
    end

    // ack only answers a request seen on the previous edge
    a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(vec_ack) |-> $past(vec_req));

    a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.mem.ld_inst && ctrl.mem.st_inst));

    a_csr_sel_wr: assert property (@(posedge clk) disable iff (rst)
        (ctrl.cfg.vl_sel || ctrl.cfg.vtype_sel) |-> ctrl.cfg.csr_wr_en);

endmodule

/* hdl/vec_decode_top.sv */
`timescale 1ns/10ps

module vec_decode_top import vec_decode_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              vec_req,
    input  logic [inst_w-1:0] vec_inst,
    output logic              vec_ack,
    output vec_ctrl_t         ctrl
);

    vec_inst_u inst_q;
    vec_ctrl_t arith_ctrl;
    vec_ctrl_t cfg_ctrl;
    vec_ctrl_t mem_ctrl;

    vec_issue_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .vec_req    (vec_req),
        .vec_inst   (vec_inst),
        .vec_ack    (vec_ack),
        .inst_q     (inst_q),
        .arith_ctrl (arith_ctrl),
        .cfg_ctrl   (cfg_ctrl),
        .mem_ctrl   (mem_ctrl),
        .ctrl       (ctrl)
    );

    vec_arith_decode u_arith (.inst(inst_q), .ctrl(arith_ctrl));
    vec_cfg_decode   u_cfg   (.inst(inst_q), .ctrl(cfg_ctrl));
    vec_mem_decode   u_mem   (.inst(inst_q), .ctrl(mem_ctrl));

endmodule

/* tb/tb_vec_decode.sv */
`timescale 1ns/10ps

module tb_vec_decode import vec_decode_pkg::*;;

    logic              clk;
    logic              rst;
    logic              vec_req;
    logic [inst_w-1:0] vec_inst;
    logic              vec_ack;
    vec_ctrl_t         ctrl;

    string             names[$];
    logic [31:0]       insts[$];
    vec_ctrl_t         exps[$];
    int                cycles;

    vec_decode_top DUT (
        .clk      (clk),
        .rst      (rst),
        .vec_req  (vec_req),
        .vec_inst (vec_inst),
        .vec_ack  (vec_ack),
        .ctrl     (ctrl)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit scales with the table size
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > names.size() * 8 + 20) begin
            $display("timeout: handshake did not complete within %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    function automatic logic [31:0] op_word(logic [5:0] f6, v_func3_e f3);
        return {f6, 1'b1, 5'd2, 5'd3, f3, 5'd1, V_ARITH};  // vs2=2 vs1=3 vd=1
    endfunction

    function automatic logic [31:0] vset_word(logic hi, logic ivli, logic [4:0] rs1,
                                              logic [4:0] rd);
        return {hi, ivli, 10'h010, rs1, CONF, rd, V_ARITH};
    endfunction

    function automatic logic [31:0] ldst_word(v_opcode_e opc, mop_e mop);
        return {3'b000, 1'b0, mop, 1'b1, 5'd4, 5'd5, 3'b000, 5'd6, opc};
    endfunction

    // fl holds sub_ctrl add sub rsub sll srl sra mul low high signed
    function automatic vec_ctrl_t alu_expect(mux1_sel_e m, exe_unit_e u, logic [10:0] fl);
        vec_ctrl_t c;
        c = '0;
        c.opnd.vec_reg_wr_en = 1'b1;
        c.opnd.data_mux1_sel = m;
        c.exe.exe_en         = 1'b1;
        c.exe.exe_unit       = u;
        {c.exe.sub_ctrl, c.exe.add_inst, c.exe.sub_inst, c.exe.rsub_inst, c.exe.sll_inst,
         c.exe.srl_inst, c.exe.sra_inst, c.exe.mul_inst, c.exe.mul_low, c.exe.mul_high,
         c.exe.signed_mode} = fl;
        return c;
    endfunction

    function automatic vec_ctrl_t csr_expect(logic vl, logic vt, logic de);
        vec_ctrl_t c;
        c = '0;
        c.cfg = {1'b1, vl, vt, de};
        return c;
    endfunction

    // addr holds stride index unordered offset
    // sel holds mux2 sew vlmax emul
    function automatic vec_ctrl_t lsu_expect(logic ld, logic [3:0] addr, logic [3:0] sel);
        vec_ctrl_t c;
        c = '0;
        c.mem.ld_inst        = ld;
        c.mem.st_inst        = ~ld;
        c.opnd.vec_reg_wr_en = 1'b1;
        c.opnd.data_mux1_sel = MUX1_SCALAR;
        {c.mem.stride_sel, c.mem.index_str, c.mem.index_unordered, c.mem.offset_vec_en} = addr;
        {c.opnd.data_mux2_sel, c.opnd.sew_eew_sel, c.opnd.vlmax_evlmax_sel,
         c.opnd.emul_vlmul_sel} = sel;
        return c;
    endfunction

    task automatic add_row(string name, logic [31:0] inst, vec_ctrl_t exp);
        names.push_back(name);
        insts.push_back(inst);
        exps.push_back(exp);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "check failed in %s", name);
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic run_row(int i);
        int n;
        n = 0;
        vec_inst = insts[i];
        vec_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!vec_ack);
        check_value({names[i], " ack latency"}, 32'd2, n);
        check_value(names[i], exps[i], ctrl);
        #1;
        vec_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (vec_ack);
        check_value({names[i], " ack release"}, 32'd1, n);
        check_value({names[i], " ctrl hold"}, exps[i], ctrl);
        #1;
    endtask

    initial begin
        cycles   = 0;
        rst      = 1'b1;
        vec_req  = 1'b0;
        vec_inst = '0;

        add_row("vadd_vv", op_word(VADD, OPIVV),
                alu_expect(MUX1_VEC, EXE_ADDSUB, 11'b0_1_0_0_0_0_0_0_0_0_0));
        add_row("vadd_vx", op_word(VADD, OPIVX),
                alu_expect(MUX1_SCALAR, EXE_ADDSUB, 11'b0_1_0_0_0_0_0_0_0_0_0));
        add_row("vadd_vi", op_word(VADD, OPIVI),
                alu_expect(MUX1_IMM, EXE_ADDSUB, 11'b0_1_0_0_0_0_0_0_0_0_0));
        add_row("vsub_vv", op_word(VSUB, OPIVV),
                alu_expect(MUX1_VEC, EXE_ADDSUB, 11'b1_0_1_0_0_0_0_0_0_0_0));
        add_row("vrsub_vx", op_word(VRSUB, OPIVX),
                alu_expect(MUX1_SCALAR, EXE_ADDSUB, 11'b1_0_0_1_0_0_0_0_0_0_0));
        add_row("vsll_vv", op_word(VSLL, OPIVV),
                alu_expect(MUX1_VEC, EXE_SHIFT, 11'b0_0_0_0_1_0_0_0_0_0_0));
        add_row("vsll_vx", op_word(VSLL, OPIVX),
                alu_expect(MUX1_SCALAR, EXE_SHIFT, 11'b0));
        add_row("vand_vv", op_word(VAND, OPIVV),
                alu_expect(MUX1_VEC, EXE_LOGIC, 11'b0));
        add_row("vmul_vv", op_word(VMUL, OPMVV),
                alu_expect(MUX1_VEC, EXE_MUL, 11'b0_0_0_0_0_0_0_1_1_0_1));
        add_row("vmulh_vv", op_word(VMULH, OPMVV),
                alu_expect(MUX1_VEC, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_1));
        add_row("vmulhu_vv", op_word(VMULHU, OPMVV),
                alu_expect(MUX1_VEC, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_0));
        add_row("vmulhsu_vv", op_word(VMULHSU, OPMVV),
                alu_expect(MUX1_VEC, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_1));
        add_row("vmul_vx", op_word(VMUL, OPMVX),
                alu_expect(MUX1_SCALAR, EXE_MUL, 11'b0_0_0_0_0_0_0_1_1_0_1));
        add_row("vmulh_vx", op_word(VMULH, OPMVX),
                alu_expect(MUX1_SCALAR, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_1));
        add_row("vmulhu_vx", op_word(VMULHU, OPMVX),
                alu_expect(MUX1_SCALAR, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_0));
        add_row("vmulhsu_vx", op_word(VMULHSU, OPMVX),
                alu_expect(MUX1_SCALAR, EXE_MUL, 11'b0_0_0_0_0_0_0_1_0_1_1));
        add_row("vsetvli_vlmax", vset_word(1'b0, 1'b0, 5'd0, 5'd5),
                csr_expect(1'b0, 1'b1, 1'b0));
        add_row("vsetvli_avl", vset_word(1'b0, 1'b0, 5'd3, 5'd5),
                csr_expect(1'b0, 1'b1, 1'b1));
        add_row("vsetivli", vset_word(1'b1, 1'b1, 5'd4, 5'd5),
                csr_expect(1'b1, 1'b1, 1'b1));
        add_row("vsetvl", vset_word(1'b1, 1'b0, 5'd3, 5'd5),
                csr_expect(1'b0, 1'b0, 1'b1));
        add_row("vle_unit", ldst_word(V_LOAD, MOP_UNIT),
                lsu_expect(1'b1, 4'b1_0_0_0, 4'b1_1_1_1));
        add_row("vle_strided", ldst_word(V_LOAD, MOP_STRIDED),
                lsu_expect(1'b1, 4'b0_0_0_0, 4'b1_1_1_1));
        add_row("vle_idx_unord", ldst_word(V_LOAD, MOP_IDX_UNORD),
                lsu_expect(1'b1, 4'b0_1_1_1, 4'b0_0_1_0));
        add_row("vle_idx_ord", ldst_word(V_LOAD, MOP_IDX_ORD),
                lsu_expect(1'b1, 4'b0_1_0_1, 4'b0_0_1_0));
        add_row("vse_unit", ldst_word(V_STORE, MOP_UNIT),
                lsu_expect(1'b0, 4'b1_0_0_0, 4'b1_1_1_1));
        add_row("vse_strided", ldst_word(V_STORE, MOP_STRIDED),
                lsu_expect(1'b0, 4'b0_0_0_0, 4'b1_1_1_1));
        add_row("vse_idx_unord", ldst_word(V_STORE, MOP_IDX_UNORD),
                lsu_expect(1'b0, 4'b0_1_1_1, 4'b0_0_1_0));
        add_row("vse_idx_ord", ldst_word(V_STORE, MOP_IDX_ORD),
                lsu_expect(1'b0, 4'b0_1_0_1, 4'b0_0_1_0));
        add_row("unknown_opcode", 32'h0020_81b3, '0);   // scalar add instruction

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value("reset ack", 32'd0, {31'b0, vec_ack});
        check_value("reset ctrl", 32'd0, ctrl);

        for (int i = 0; i < names.size(); i++) begin
            run_row(i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* vec_decode.f */
hdl/vec_decode_pkg.sv
hdl/vec_arith_decode.sv
hdl/vec_cfg_decode.sv
hdl/vec_mem_decode.sv
hdl/vec_issue_fsm.sv
hdl/vec_decode_top.sv
tb/tb_vec_decode.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f vec_decode.f \
		--top-module tb_vec_decode -o sim_vec_decode
	./obj_dir/sim_vec_decode | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
